// File: sum_data_pkg.sv
// Data package for the vector summation unit with element and count widths
`default_nettype none

package sum_data_pkg;

  //////////////////////////////////////////////////////////////////////
  // Element data
  //////////////////////////////////////////////////////////////////////

  // Width of one element and of every running sum
  localparam int data_width = 32;

  // One element or one sum on the data path
  typedef logic [data_width-1:0] data_word_t;

  //////////////////////////////////////////////////////////////////////
  // Counts and loop indices
  //////////////////////////////////////////////////////////////////////

  // Width of vector and element counts
  localparam int count_width = 16;

  // SIZE_IN, LENGTH_IN and both loop indices
  typedef logic [count_width-1:0] count_t;

endpackage : sum_data_pkg

`default_nettype wire

// File: sum_ctrl_pkg.sv
// Control package for the vector summation unit with the FSM state encoding
`default_nettype none

package sum_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // FSM encoding
  //////////////////////////////////////////////////////////////////////

  // Bits needed for the three control states
  localparam int state_width = 2;

  // Control FSM states
  // idle waits for START, vector_wait for the first element of a vector,
  // element_wait for every later element of the same vector
  typedef enum logic [state_width-1:0] {
    idle         = 2'd0,
    vector_wait  = 2'd1,
    element_wait = 2'd2
  } ctrl_state_t;

endpackage : sum_ctrl_pkg

`default_nettype wire

// File: loop_index_counter.sv
// Loop index counter that loads a limit, steps with wrap-around and flags its last value
`timescale 1ns/1ns
`default_nettype none

module loop_index_counter (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  load,
  input  sum_data_pkg::count_t limit,
  input  wire                  step,
  output sum_data_pkg::count_t index,
  output logic                 last
);

  import sum_data_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Limit captured at load time
  count_t limit_q;

  // Final index of the loop
  count_t last_value;

  //////////////////////////////////////////////////////////////////////
  // Limit register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      limit_q <= '0;
    end else if (load) begin
      limit_q <= limit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Index register
  //////////////////////////////////////////////////////////////////////

  // Load has priority over step
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index <= '0;
    end else if (load) begin
      index <= '0;
    end else if (step) begin
      // Wrap back to zero after the last value
      if (last) begin
        index <= '0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

  // Last flag straight from the registers, no extra cycle
  assign last_value = limit_q - 1'b1;
  assign last       = (index == last_value);

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Once a nonzero limit is held the index stays below it
  a_index_below_limit : assert property (
    @(posedge CLK) disable iff (RST)
    (limit_q != '0) |-> (index < limit_q)
  );

endmodule : loop_index_counter

`default_nettype wire

// File: scalar_accumulator.sv
// Scalar accumulator that restarts on a first element and adds every later one
`timescale 1ns/1ns
`default_nettype none

module scalar_accumulator (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire                      first,
  input  wire                      add,
  input  sum_data_pkg::data_word_t data_in,
  output sum_data_pkg::data_word_t sum
);

  import sum_data_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Next sum
  //////////////////////////////////////////////////////////////////////

  // Value the sum register takes at the next edge
  data_word_t sum_next;

  always_comb begin
    sum_next = sum;
    if (first) begin
      // New vector so drop the old sum
      sum_next = data_in;
    end else if (add) begin
      // Plain unsigned add, carry out is lost
      sum_next = sum + data_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sum register
  //////////////////////////////////////////////////////////////////////

  // DATA_OUT reads zero after reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else begin
      sum <= sum_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // The controller never restarts and adds on the same element
  a_first_add_exclusive : assert property (
    @(posedge CLK) disable iff (RST)
    !(first && add)
  );

endmodule : scalar_accumulator

`default_nettype wire

// File: summation_ctrl.sv
// Summation controller FSM that accepts strobes, sequences both loops and issues result pulses
`timescale 1ns/1ns
`default_nettype none

module summation_ctrl (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  start,
  input  sum_data_pkg::count_t size_in,
  input  sum_data_pkg::count_t length_in,
  input  wire                  vector_strobe,
  input  wire                  element_strobe,
  input  wire                  vector_last,
  input  wire                  element_last,
  output logic                 vector_load,
  output logic                 element_load,
  output logic                 vector_step,
  output logic                 element_step,
  output logic                 acc_first,
  output logic                 acc_add,
  output logic                 ready,
  output logic                 vector_done,
  output logic                 element_done
);

  import sum_ctrl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // FSM state
  ctrl_state_t state;
  ctrl_state_t state_next;

  // Both counts nonzero
  logic counts_valid;

  // Accepted strobes for this cycle
  logic start_accept;
  logic vector_accept;
  logic element_accept;
  logic any_accept;

  // End of a vector and end of the whole run
  logic vector_end;
  logic run_end;

  //////////////////////////////////////////////////////////////////////
  // Strobe acceptance
  //////////////////////////////////////////////////////////////////////

  // Zero vectors or zero elements means nothing to do
  assign counts_valid = (size_in != '0) && (length_in != '0);

  // Each strobe only counts in its own state
  assign start_accept   = (state == idle) && start && counts_valid;
  assign vector_accept  = (state == vector_wait) && vector_strobe;
  assign element_accept = (state == element_wait) && element_strobe;
  assign any_accept     = vector_accept || element_accept;

  // Loop ends seen on the element being accepted
  assign vector_end = any_accept && element_last;
  assign run_end    = vector_end && vector_last;

  //////////////////////////////////////////////////////////////////////
  // Counter and accumulator control
  //////////////////////////////////////////////////////////////////////

  // Both loops restart on an accepted START
  assign vector_load  = start_accept;
  assign element_load = start_accept;

  // Element index moves on every element and wraps per vector
  assign element_step = any_accept;
  assign vector_step  = vector_end;

  // First element restarts the sum, later ones add
  assign acc_first = vector_accept;
  assign acc_add   = element_accept;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (start_accept) begin
          state_next = vector_wait;
        end
      end
      vector_wait: begin
        if (vector_accept) begin
          // Single element vectors skip element_wait
          if (run_end) begin
            state_next = idle;
          end else if (vector_end) begin
            state_next = vector_wait;
          end else begin
            state_next = element_wait;
          end
        end
      end
      element_wait: begin
        if (element_accept) begin
          if (run_end) begin
            state_next = idle;
          end else if (vector_end) begin
            state_next = vector_wait;
          end
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and output pulses
  //////////////////////////////////////////////////////////////////////

  // Pulses line up with the new sum from the accumulator
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= idle;
      element_done <= 1'b0;
      vector_done  <= 1'b0;
      ready        <= 1'b0;
    end else begin
      state        <= state_next;
      element_done <= any_accept;
      vector_done  <= vector_end;
      ready        <= run_end;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Final result closes a vector and an element and leaves the FSM idle
  a_ready_closes_vector : assert property (
    @(posedge CLK) disable iff (RST)
    ready |-> (vector_done && element_done && state == idle)
  );

  // At most one element per cycle reaches the accumulator
  a_single_accept : assert property (
    @(posedge CLK) disable iff (RST)
    !(vector_accept && element_accept)
  );

endmodule : summation_ctrl

`default_nettype wire

// File: vector_summation.sv
// Vector summation unit top level joining the controller, both loop counters and the accumulator
`timescale 1ns/1ns
`default_nettype none

module vector_summation (
  // Global
  input  wire                      CLK,
  input  wire                      RST,

  // Control
  input  wire                      START,
  output wire                      READY,
  input  wire                      DATA_IN_VECTOR_ENABLE,
  input  wire                      DATA_IN_SCALAR_ENABLE,
  output wire                      DATA_OUT_VECTOR_ENABLE,
  output wire                      DATA_OUT_SCALAR_ENABLE,

  // Data
  input  sum_data_pkg::count_t     SIZE_IN,
  input  sum_data_pkg::count_t     LENGTH_IN,
  input  sum_data_pkg::data_word_t DATA_IN,
  output sum_data_pkg::data_word_t DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////

  // Vector loop
  wire vector_load;
  wire vector_step;
  wire vector_last;

  // Element loop
  wire element_load;
  wire element_step;
  wire element_last;

  // Accumulator control
  wire acc_first;
  wire acc_add;

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  summation_ctrl i_summation_ctrl (
    .CLK            (CLK),
    .RST            (RST),
    .start          (START),
    .size_in        (SIZE_IN),
    .length_in      (LENGTH_IN),
    .vector_strobe  (DATA_IN_VECTOR_ENABLE),
    .element_strobe (DATA_IN_SCALAR_ENABLE),
    .vector_last    (vector_last),
    .element_last   (element_last),
    .vector_load    (vector_load),
    .element_load   (element_load),
    .vector_step    (vector_step),
    .element_step   (element_step),
    .acc_first      (acc_first),
    .acc_add        (acc_add),
    .ready          (READY),
    .vector_done    (DATA_OUT_VECTOR_ENABLE),
    .element_done   (DATA_OUT_SCALAR_ENABLE)
  );

  //////////////////////////////////////////////////////////////////////
  // Loop counters
  //////////////////////////////////////////////////////////////////////

  // Counts vectors up to SIZE_IN
  loop_index_counter vector_index (
    .CLK   (CLK),
    .RST   (RST),
    .load  (vector_load),
    .limit (SIZE_IN),
    .step  (vector_step),
    .index (),
    .last  (vector_last)
  );

  // Counts elements up to LENGTH_IN, wraps once per vector
  loop_index_counter element_index (
    .CLK   (CLK),
    .RST   (RST),
    .load  (element_load),
    .limit (LENGTH_IN),
    .step  (element_step),
    .index (),
    .last  (element_last)
  );

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // Running sum goes straight out as DATA_OUT
  scalar_accumulator i_scalar_accumulator (
    .CLK     (CLK),
    .RST     (RST),
    .first   (acc_first),
    .add     (acc_add),
    .data_in (DATA_IN),
    .sum     (DATA_OUT)
  );

endmodule : vector_summation

`default_nettype wire

// File: summation_model.svh
// Reference model of the expected running sums and result pulses of the vector summation unit
`ifndef SUMMATION_MODEL_SVH
`define SUMMATION_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Model state
//////////////////////////////////////////////////////////////////////

// Model FSM encoding
localparam int m_idle         = 0;
localparam int m_vector_wait  = 1;
localparam int m_element_wait = 2;

int m_state;
int m_vec_idx;
int m_elem_idx;
int m_size;
int m_length;

// Expected outputs in the cycle after an edge
data_word_t exp_sum;
logic       exp_scalar;
logic       exp_vector;
logic       exp_ready;

task automatic model_reset();
  m_state    = m_idle;
  m_vec_idx  = 0;
  m_elem_idx = 0;
  m_size     = 0;
  m_length   = 0;
  exp_sum    = '0;
  exp_scalar = 1'b0;
  exp_vector = 1'b0;
  exp_ready  = 1'b0;
endtask

// One rising edge with the inputs sampled at that edge
task automatic model_clock(input logic start, input count_t size, input count_t length,
                           input logic vec_en, input logic sc_en, input data_word_t data);
  logic take;
  logic restart;
  take       = 1'b0;
  restart    = 1'b0;
  exp_scalar = 1'b0;
  exp_vector = 1'b0;
  exp_ready  = 1'b0;
  case (m_state)
    m_idle: begin
      // Zero counts leave the model idle
      if (start && size != 0 && length != 0) begin
        m_size     = size;
        m_length   = length;
        m_vec_idx  = 0;
        m_elem_idx = 0;
        m_state    = m_vector_wait;
      end
    end
    m_vector_wait: begin
      take    = vec_en;
      restart = 1'b1;
    end
    default: begin
      take = sc_en;
    end
  endcase
  if (take) begin
    // Unsigned sum, carry out dropped
    exp_sum    = restart ? data : exp_sum + data;
    exp_scalar = 1'b1;
    m_elem_idx = m_elem_idx + 1;
    m_state    = m_element_wait;
    if (m_elem_idx == m_length) begin
      m_elem_idx = 0;
      m_vec_idx  = m_vec_idx + 1;
      exp_vector = 1'b1;
      m_state    = m_vector_wait;
      if (m_vec_idx == m_size) begin
        exp_ready = 1'b1;
        m_state   = m_idle;
      end
    end
  end
endtask

`endif

// File: tb_vector_summation.sv
// Testbench for the vector summation unit with random jobs checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_vector_summation;

  import sum_data_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Settings and signals
  //////////////////////////////////////////////////////////////////////

  localparam int clk_half      = 20;
  localparam int drive_delay   = 5;
  localparam int job_count     = 40;
  localparam int ready_timeout = 8;

  logic       CLK;
  logic       RST;
  logic       START;
  count_t     SIZE_IN;
  count_t     LENGTH_IN;
  data_word_t DATA_IN;
  logic       DATA_IN_VECTOR_ENABLE;
  logic       DATA_IN_SCALAR_ENABLE;
  wire        READY;
  wire        DATA_OUT_VECTOR_ENABLE;
  wire        DATA_OUT_SCALAR_ENABLE;
  data_word_t DATA_OUT;

  integer seed;
  int     errors;
  int     timeouts;

  `include "summation_model.svh"

  vector_summation i_vector_summation (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (START),
    .READY                  (READY),
    .DATA_IN_VECTOR_ENABLE  (DATA_IN_VECTOR_ENABLE),
    .DATA_IN_SCALAR_ENABLE  (DATA_IN_SCALAR_ENABLE),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE),
    .SIZE_IN                (SIZE_IN),
    .LENGTH_IN              (LENGTH_IN),
    .DATA_IN                (DATA_IN),
    .DATA_OUT               (DATA_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #clk_half CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic check_outputs();
    assert (DATA_OUT === exp_sum) else begin
      errors++;
      $display("CHECK FAILED DATA_OUT expected %h got %h at %0t", exp_sum, DATA_OUT, $time);
    end
    assert (DATA_OUT_SCALAR_ENABLE === exp_scalar) else begin
      errors++;
      $display("CHECK FAILED DATA_OUT_SCALAR_ENABLE expected %h got %h at %0t",
               exp_scalar, DATA_OUT_SCALAR_ENABLE, $time);
    end
    assert (DATA_OUT_VECTOR_ENABLE === exp_vector) else begin
      errors++;
      $display("CHECK FAILED DATA_OUT_VECTOR_ENABLE expected %h got %h at %0t",
               exp_vector, DATA_OUT_VECTOR_ENABLE, $time);
    end
    assert (READY === exp_ready) else begin
      errors++;
      $display("CHECK FAILED READY expected %h got %h at %0t", exp_ready, READY, $time);
    end
  endtask

  // Called just after an edge; inputs hold over the next edge, outputs checked after it
  task automatic drive_cycle(input logic start, input count_t size, input count_t length,
                             input logic vec_en, input logic sc_en, input data_word_t data);
    START                 = start;
    SIZE_IN               = size;
    LENGTH_IN             = length;
    DATA_IN_VECTOR_ENABLE = vec_en;
    DATA_IN_SCALAR_ENABLE = sc_en;
    DATA_IN               = data;
    @(posedge CLK);
    model_clock(start, size, length, vec_en, sc_en, data);
    #drive_delay;
    check_outputs();
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  // Near max values force the sum to wrap
  function automatic data_word_t rand_element(input logic near_max);
    data_word_t value;
    value = $random(seed);
    if (near_max) begin
      value = '1 - (value & 32'h0000_00ff);
    end
    return value;
  endfunction

  // Wrong strobe kind, START while busy, or a quiet cycle
  task automatic noise_cycle(input logic in_first);
    int pick;
    pick = {$random(seed)} % 4;
    case (pick)
      0: drive_cycle(1'b0, '0, '0, !in_first, in_first, rand_element(1'b0));
      1: drive_cycle(1'b1, count_t'(1 + {$random(seed)} % 4), count_t'(1 + {$random(seed)} % 6),
                     1'b0, 1'b0, rand_element(1'b0));
      default: idle_cycle();
    endcase
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (READY !== 1'b1 && waited < ready_timeout) begin
      idle_cycle();
      waited++;
    end
    if (READY !== 1'b1) begin
      errors++;
      timeouts++;
      $display("Timed out after %0d cycles waiting for READY at %0t", waited, $time);
    end
  endtask

  // One START, then every element with random gaps full of ignored inputs
  task automatic run_job(input count_t size, input count_t length, input logic near_max);
    int v;
    int e;
    int g;
    int gap;
    drive_cycle(1'b1, size, length, 1'b0, 1'b0, '0);
    for (v = 0; v < size; v++) begin
      for (e = 0; e < length; e++) begin
        gap = {$random(seed)} % 3;
        for (g = 0; g < gap; g++) begin
          noise_cycle(e == 0);
        end
        drive_cycle(1'b0, '0, '0, e == 0, e != 0, rand_element(near_max));
      end
    end
    wait_ready();
    idle_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int job;
    seed                  = 32'h9eb1_3cd8;
    errors                = 0;
    timeouts              = 0;
    RST                   = 1'b1;
    START                 = 1'b0;
    SIZE_IN               = '0;
    LENGTH_IN             = '0;
    DATA_IN               = '0;
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
    model_reset();
    repeat (2) @(posedge CLK);
    #drive_delay;
    RST = 1'b0;
    // Quiet outputs before any START
    check_outputs();
    idle_cycle();
    // Zero counts and stray strobes in idle
    drive_cycle(1'b1, count_t'(0), count_t'(3), 1'b0, 1'b0, '0);
    drive_cycle(1'b1, count_t'(2), count_t'(0), 1'b0, 1'b0, '0);
    drive_cycle(1'b0, '0, '0, 1'b1, 1'b1, rand_element(1'b0));
    run_job(count_t'(2), count_t'(3), 1'b0);
    // Several near max elements in one vector so the sum wraps
    run_job(count_t'(1), count_t'(4), 1'b1);
    for (job = 0; job < job_count && timeouts == 0; job++) begin
      run_job(count_t'(1 + {$random(seed)} % 4), count_t'(1 + {$random(seed)} % 6),
              job % 4 == 3);
    end
    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_vector_summation

`default_nettype wire

// File: src.f
+incdir+.
sum_data_pkg.sv
sum_ctrl_pkg.sv
loop_index_counter.sv
scalar_accumulator.sv
summation_ctrl.sv
vector_summation.sv
tb_vector_summation.sv
